//--- pmp_pkg.sv
`default_nettype none

package pmp_pkg;

  // Number of PMP entries
  localparam int NUM_REGIONS = 4;

  // Register port address width in bits
  localparam int AXI_ADDR_W = 8;

  // Register map, byte offsets
  localparam logic [AXI_ADDR_W-1:0] ADDR_PMPCFG0  = 8'h00;
  // pmpaddr registers follow at a stride of 4
  localparam logic [AXI_ADDR_W-1:0] ADDR_PMPADDR0 = 8'h10;
  localparam logic [AXI_ADDR_W-1:0] ADDR_MSECCFG  = 8'h20;

  // Data word on the register port
  typedef logic [31:0] word_t;

  // One configuration byte per entry
  typedef logic [7:0] pmp_cfg_t;

  // Holds bits 33..2 of a physical address
  typedef logic [31:0] pmp_addr_t;

  // Byte address of an access request
  typedef logic [31:0] phys_addr_t;

  // One bit per region
  typedef logic [NUM_REGIONS-1:0] region_vec_t;

  // Privilege level of a request
  typedef logic [1:0] priv_t;

  localparam priv_t PRIV_U = 2'd0;
  localparam priv_t PRIV_M = 2'd3;

  // Configuration byte fields
  localparam int CFG_R_BIT = 0;
  localparam int CFG_W_BIT = 1;
  localparam int CFG_X_BIT = 2;
  // A field is two bits starting here
  localparam int CFG_A_LO  = 3;
  localparam int CFG_L_BIT = 7;

  // Reserved bits 6 and 5, always read as zero
  localparam pmp_cfg_t CFG_ZERO_MASK = 8'h60;

  // Rule locking bypass in mseccfg
  localparam int MSECCFG_RLB_BIT = 2;

  // Address matching modes
  localparam logic [1:0] A_OFF   = 2'd0;
  localparam logic [1:0] A_TOR   = 2'd1;
  localparam logic [1:0] A_NA4   = 2'd2;
  localparam logic [1:0] A_NAPOT = 2'd3;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // Kind of access being checked
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } access_e;

endpackage

`default_nettype wire

//--- pmp_csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module pmp_csr_regs (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // AXI4-Lite write channels
  input  logic                                          s_awvalid_i,
  output logic                                          s_awready_o,
  input  logic [pmp_pkg::AXI_ADDR_W-1:0]                s_awaddr_i,
  input  logic                                          s_wvalid_i,
  output logic                                          s_wready_o,
  input  pmp_pkg::word_t                                s_wdata_i,
  input  logic [3:0]                                    s_wstrb_i,
  output logic                                          s_bvalid_o,
  input  logic                                          s_bready_i,
  output logic [1:0]                                    s_bresp_o,
  // AXI4-Lite read channels
  input  logic                                          s_arvalid_i,
  output logic                                          s_arready_o,
  input  logic [pmp_pkg::AXI_ADDR_W-1:0]                s_araddr_i,
  output logic                                          s_rvalid_o,
  input  logic                                          s_rready_i,
  output pmp_pkg::word_t                                s_rdata_o,
  output logic [1:0]                                    s_rresp_o,
  // Current configuration for the pipeline
  output pmp_pkg::pmp_cfg_t  [pmp_pkg::NUM_REGIONS-1:0] cfg_o,
  output pmp_pkg::pmp_addr_t [pmp_pkg::NUM_REGIONS-1:0] addr_o
);

  pmp_pkg::pmp_cfg_t  [pmp_pkg::NUM_REGIONS-1:0] cfg_q;
  pmp_pkg::pmp_addr_t [pmp_pkg::NUM_REGIONS-1:0] addr_q;
  logic                                          rlb_q;

  logic                 bvalid_q;
  logic [1:0]           bresp_q;
  logic                 rvalid_q;
  pmp_pkg::word_t       rdata_q;
  logic [1:0]           rresp_q;

  logic                 wr_fire;
  logic                 rd_fire;
  pmp_pkg::region_vec_t aw_sel;
  pmp_pkg::region_vec_t ar_sel;
  logic                 aw_mapped;
  pmp_pkg::word_t       rd_data;
  logic                 rd_mapped;

  pmp_pkg::region_vec_t lock_vec;
  pmp_pkg::region_vec_t lock_nb;
  pmp_pkg::region_vec_t tor_lock_nb;
  pmp_pkg::region_vec_t addr_frozen;

  // One-hot select of the pmpaddr register at a given offset
  function automatic pmp_pkg::region_vec_t pmpaddr_sel(
    input logic [pmp_pkg::AXI_ADDR_W-1:0] offs
  );
    pmp_pkg::region_vec_t sel;
    sel = '0;
    for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
      if (offs == pmp_pkg::ADDR_PMPADDR0 + pmp_pkg::AXI_ADDR_W'(4 * i)) begin
        sel[i] = 1'b1;
      end
    end
    return sel;
  endfunction

  // WARL legalization of one written cfg byte
  function automatic pmp_pkg::pmp_cfg_t legal_cfg(
    input pmp_pkg::pmp_cfg_t old_cfg,
    input pmp_pkg::pmp_cfg_t wr_cfg,
    input logic              rlb
  );
    pmp_pkg::pmp_cfg_t res;
    res = wr_cfg;
    // W without R is reserved, keep the previous RWX
    if (wr_cfg[pmp_pkg::CFG_X_BIT:pmp_pkg::CFG_R_BIT] inside {3'd2, 3'd6}) begin
      res[pmp_pkg::CFG_X_BIT:pmp_pkg::CFG_R_BIT] =
        old_cfg[pmp_pkg::CFG_X_BIT:pmp_pkg::CFG_R_BIT];
    end
    if (old_cfg[pmp_pkg::CFG_L_BIT] && !rlb) begin
      res = old_cfg;
    end
    res = res & ~pmp_pkg::CFG_ZERO_MASK;
    return res;
  endfunction

  // Address and data are taken in the same cycle
  assign wr_fire     = s_awvalid_i & s_wvalid_i & ~bvalid_q;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;

  assign rd_fire     = s_arvalid_i & ~rvalid_q;
  assign s_arready_o = rd_fire;

  assign aw_sel    = pmpaddr_sel(s_awaddr_i);
  assign ar_sel    = pmpaddr_sel(s_araddr_i);
  assign aw_mapped = (s_awaddr_i == pmp_pkg::ADDR_PMPCFG0) | (|aw_sel) |
                     (s_awaddr_i == pmp_pkg::ADDR_MSECCFG);

  // Lock state per entry
  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : g_lock
    assign lock_vec[i]    = cfg_q[i][pmp_pkg::CFG_L_BIT];
    assign lock_nb[i]     = lock_vec[i] & ~rlb_q;
    assign tor_lock_nb[i] = lock_nb[i] &
                            (cfg_q[i][pmp_pkg::CFG_A_LO +: 2] == pmp_pkg::A_TOR);
  end

  // A locked TOR entry also freezes the address below it
  assign addr_frozen = lock_nb | (tor_lock_nb >> 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else if (wr_fire) begin
      if (s_awaddr_i == pmp_pkg::ADDR_PMPCFG0) begin
        for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
          cfg_q[i] <= legal_cfg(cfg_q[i], s_wdata_i[8*i +: 8], rlb_q);
        end
      end
      for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
        if (aw_sel[i] && !addr_frozen[i]) begin
          addr_q[i] <= s_wdata_i;
        end
      end
      // RLB can only be raised while nothing is locked
      if (s_awaddr_i == pmp_pkg::ADDR_MSECCFG) begin
        rlb_q <= s_wdata_i[pmp_pkg::MSECCFG_RLB_BIT] & (rlb_q | ~(|lock_vec));
      end
    end
  end

  // Write response, strobes play no part since only full words are written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (s_bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= aw_mapped ? pmp_pkg::RESP_OKAY : pmp_pkg::RESP_SLVERR;
    end
  end

  // Read data mux
  always_comb begin
    rd_data   = '0;
    rd_mapped = 1'b1;
    if (s_araddr_i == pmp_pkg::ADDR_PMPCFG0) begin
      rd_data = pmp_pkg::word_t'(cfg_q);
    end else if (|ar_sel) begin
      for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
        if (ar_sel[i]) begin
          rd_data = addr_q[i];
        end
      end
    end else if (s_araddr_i == pmp_pkg::ADDR_MSECCFG) begin
      rd_data[pmp_pkg::MSECCFG_RLB_BIT] = rlb_q;
    end else begin
      rd_mapped = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // Data stays put until the response is taken
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_mapped ? pmp_pkg::RESP_OKAY : pmp_pkg::RESP_SLVERR;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = rresp_q;
  assign cfg_o      = cfg_q;
  assign addr_o     = addr_q;

endmodule

`default_nettype wire

//--- pmp_region_match.sv
`timescale 1ns/10ps
`default_nettype none

module pmp_region_match (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Incoming access request
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  input  pmp_pkg::phys_addr_t                           req_addr_i,
  input  pmp_pkg::access_e                              req_type_i,
  input  pmp_pkg::priv_t                                req_priv_i,
  // Region configuration
  input  pmp_pkg::pmp_cfg_t  [pmp_pkg::NUM_REGIONS-1:0] cfg_i,
  input  pmp_pkg::pmp_addr_t [pmp_pkg::NUM_REGIONS-1:0] addr_i,
  // To the priority stage
  output logic                                          s1_valid_o,
  output pmp_pkg::region_vec_t                          s1_match_o,
  output pmp_pkg::access_e                              s1_type_o,
  output pmp_pkg::priv_t                                s1_priv_o,
  input  logic                                          s1_ready_i
);

  pmp_pkg::pmp_addr_t   word_addr;
  pmp_pkg::region_vec_t match_vec;

  logic                 s1_valid_q;
  pmp_pkg::region_vec_t s1_match_q;
  pmp_pkg::access_e     s1_type_q;
  pmp_pkg::priv_t       s1_priv_q;

  // pmpaddr registers hold word addresses
  assign word_addr = pmp_pkg::pmp_addr_t'(req_addr_i >> 2);

  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : g_region
    pmp_pkg::pmp_addr_t lo_bound;
    pmp_pkg::pmp_addr_t napot_mask;
    logic [1:0]         a_mode;
    logic               hit;

    // TOR lower bound comes from the entry below, zero for entry 0
    if (i == 0) begin : g_first
      assign lo_bound = '0;
    end else begin : g_next
      assign lo_bound = addr_i[i-1];
    end

    // Trailing ones plus the first zero span the region size
    assign napot_mask = addr_i[i] ^ (addr_i[i] + pmp_pkg::pmp_addr_t'(1));
    assign a_mode     = cfg_i[i][pmp_pkg::CFG_A_LO +: 2];

    always_comb begin
      case (a_mode)
        pmp_pkg::A_OFF: begin
          hit = 1'b0;
        end
        pmp_pkg::A_TOR: begin
          hit = (word_addr >= lo_bound) && (word_addr < addr_i[i]);
        end
        pmp_pkg::A_NA4: begin
          hit = (word_addr == addr_i[i]);
        end
        pmp_pkg::A_NAPOT: begin
          hit = ((word_addr & ~napot_mask) == (addr_i[i] & ~napot_mask));
        end
        default: begin
          hit = 1'b0;
        end
      endcase
    end

    assign match_vec[i] = hit;
  end

  // Accept when empty or when the next stage drains us
  assign req_ready_o = ~s1_valid_q | s1_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      s1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      s1_match_q <= match_vec;
      s1_type_q  <= req_type_i;
      s1_priv_q  <= req_priv_i;
    end
  end

  assign s1_valid_o = s1_valid_q;
  assign s1_match_o = s1_match_q;
  assign s1_type_o  = s1_type_q;
  assign s1_priv_o  = s1_priv_q;

endmodule

`default_nettype wire

//--- pmp_priority_check.sv
`timescale 1ns/10ps
`default_nettype none

module pmp_priority_check (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // From the match stage
  input  logic                                         s1_valid_i,
  output logic                                         s1_ready_o,
  input  pmp_pkg::region_vec_t                         s1_match_i,
  input  pmp_pkg::access_e                             s1_type_i,
  input  pmp_pkg::priv_t                               s1_priv_i,
  // Permission and lock bits
  input  pmp_pkg::pmp_cfg_t [pmp_pkg::NUM_REGIONS-1:0] cfg_i,
  // Response channel
  output logic                                         rsp_valid_o,
  output logic                                         rsp_allow_o,
  output logic                                         rsp_hit_o,
  input  logic                                         rsp_ready_i
);

  pmp_pkg::pmp_cfg_t cfg_sel;
  logic              perm;
  logic              hit;
  logic              allow;

  logic              rsp_valid_q;
  logic              rsp_allow_q;
  logic              rsp_hit_q;

  // Lowest index wins, so scan downwards
  always_comb begin
    cfg_sel = '0;
    for (int i = pmp_pkg::NUM_REGIONS - 1; i >= 0; i--) begin
      if (s1_match_i[i]) begin
        cfg_sel = cfg_i[i];
      end
    end
  end

  assign hit = |s1_match_i;

  always_comb begin
    case (s1_type_i)
      pmp_pkg::ACC_READ:  perm = cfg_sel[pmp_pkg::CFG_R_BIT];
      pmp_pkg::ACC_WRITE: perm = cfg_sel[pmp_pkg::CFG_W_BIT];
      pmp_pkg::ACC_EXEC:  perm = cfg_sel[pmp_pkg::CFG_X_BIT];
      default:            perm = 1'b0;
    endcase
  end

  always_comb begin
    if (!hit) begin
      // No region, only M mode gets through
      allow = (s1_priv_i == pmp_pkg::PRIV_M);
    end else if ((s1_priv_i == pmp_pkg::PRIV_M) && !cfg_sel[pmp_pkg::CFG_L_BIT]) begin
      allow = 1'b1;
    end else begin
      allow = perm;
    end
  end

  assign s1_ready_o = ~rsp_valid_q | rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (s1_ready_o) begin
      rsp_valid_q <= s1_valid_i;
    end
  end

  // Response held while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (s1_valid_i && s1_ready_o) begin
      rsp_allow_q <= allow;
      rsp_hit_q   <= hit;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_allow_o = rsp_allow_q;
  assign rsp_hit_o   = rsp_hit_q;

endmodule

`default_nettype wire

//--- pmp_top.sv
`timescale 1ns/10ps
`default_nettype none

module pmp_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Register port
  input  logic                           s_awvalid_i,
  output logic                           s_awready_o,
  input  logic [pmp_pkg::AXI_ADDR_W-1:0] s_awaddr_i,
  input  logic                           s_wvalid_i,
  output logic                           s_wready_o,
  input  pmp_pkg::word_t                 s_wdata_i,
  input  logic [3:0]                     s_wstrb_i,
  output logic                           s_bvalid_o,
  input  logic                           s_bready_i,
  output logic [1:0]                     s_bresp_o,
  input  logic                           s_arvalid_i,
  output logic                           s_arready_o,
  input  logic [pmp_pkg::AXI_ADDR_W-1:0] s_araddr_i,
  output logic                           s_rvalid_o,
  input  logic                           s_rready_i,
  output pmp_pkg::word_t                 s_rdata_o,
  output logic [1:0]                     s_rresp_o,
  // Access requests
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  pmp_pkg::phys_addr_t            req_addr_i,
  input  pmp_pkg::access_e               req_type_i,
  input  pmp_pkg::priv_t                 req_priv_i,
  // Access responses
  output logic                           rsp_valid_o,
  output logic                           rsp_allow_o,
  output logic                           rsp_hit_o,
  input  logic                           rsp_ready_i
);

  pmp_pkg::pmp_cfg_t  [pmp_pkg::NUM_REGIONS-1:0] regs_cfg;
  pmp_pkg::pmp_addr_t [pmp_pkg::NUM_REGIONS-1:0] regs_addr;

  logic                 s1_valid;
  logic                 s1_ready;
  pmp_pkg::region_vec_t s1_match;
  pmp_pkg::access_e     s1_type;
  pmp_pkg::priv_t       s1_priv;

  // Register file beside the pipeline
  pmp_csr_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_awaddr_i  (s_awaddr_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_bresp_o   (s_bresp_o),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_araddr_i  (s_araddr_i),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .cfg_o       (regs_cfg),
    .addr_o      (regs_addr)
  );

  // Stage 1, address match
  pmp_region_match u_match (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_type_i  (req_type_i),
    .req_priv_i  (req_priv_i),
    .cfg_i       (regs_cfg),
    .addr_i      (regs_addr),
    .s1_valid_o  (s1_valid),
    .s1_match_o  (s1_match),
    .s1_type_o   (s1_type),
    .s1_priv_o   (s1_priv),
    .s1_ready_i  (s1_ready)
  );

  // Stage 2, priority and permission
  pmp_priority_check u_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .s1_valid_i  (s1_valid),
    .s1_ready_o  (s1_ready),
    .s1_match_i  (s1_match),
    .s1_type_i   (s1_type),
    .s1_priv_i   (s1_priv),
    .cfg_i       (regs_cfg),
    .rsp_valid_o (rsp_valid_o),
    .rsp_allow_o (rsp_allow_o),
    .rsp_hit_o   (rsp_hit_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

`default_nettype wire

//--- tb_pmp_assert.sv
`timescale 1ns/10ps
`default_nettype none

module pmp_checker (
  input logic                                         clk_i,
  input logic                                         rst_ni,
  input logic                                         s_bvalid_o,
  input logic                                         s_bready_i,
  input logic                                         s_rvalid_o,
  input logic                                         s_rready_i,
  input pmp_pkg::word_t                               s_rdata_o,
  input logic                                         rsp_valid_o,
  input logic                                         rsp_ready_i,
  input logic                                         rsp_allow_o,
  input logic                                         rsp_hit_o,
  input pmp_pkg::pmp_cfg_t [pmp_pkg::NUM_REGIONS-1:0] cfg_i,
  input logic                                         rlb_i
);

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
    else $error("rvalid or rdata changed before rready");

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_allow_o) && $stable(rsp_hit_o))
    else $error("response changed under back-pressure");

  // Locked entries are frozen unless RLB is set
  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : g_lock
    a_lock_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cfg_i[i][pmp_pkg::CFG_L_BIT] && !rlb_i |=> $stable(cfg_i[i]))
      else $error("locked cfg byte changed");
  end

endmodule

bind pmp_top pmp_checker u_checker (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .s_bvalid_o  (s_bvalid_o),
  .s_bready_i  (s_bready_i),
  .s_rvalid_o  (s_rvalid_o),
  .s_rready_i  (s_rready_i),
  .s_rdata_o   (s_rdata_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_allow_o (rsp_allow_o),
  .rsp_hit_o   (rsp_hit_o),
  .cfg_i       (regs_cfg),
  .rlb_i       (u_regs.rlb_q)
);

`default_nettype wire

//--- tb_pmp.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pmp;

  localparam int TIMEOUT = 200;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic s_awvalid_i = 1'b0;
  logic s_wvalid_i = 1'b0;
  logic s_bready_i = 1'b0;
  logic s_arvalid_i = 1'b0;
  logic s_rready_i = 1'b0;
  logic [7:0] s_awaddr_i = '0;
  logic [7:0] s_araddr_i = '0;
  logic [31:0] s_wdata_i = '0;
  logic [3:0] s_wstrb_i = '0;
  logic s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
  logic [1:0] s_bresp_o, s_rresp_o;
  logic [31:0] s_rdata_o;
  logic req_valid_i = 1'b0;
  logic [31:0] req_addr_i = '0;
  pmp_pkg::access_e req_type_i = pmp_pkg::ACC_READ;
  logic [1:0] req_priv_i = '0;
  logic req_ready_o, rsp_valid_o, rsp_allow_o, rsp_hit_o;
  logic rsp_ready_i = 1'b1;

  // Reference copy of the register state
  logic [7:0]  m_cfg [4];
  logic [31:0] m_addr [4];
  logic        m_rlb;

  int errors = 0;
  int tests = 0;
  int seed = 32'h82d6;

  always #2 clk_i = ~clk_i;

  pmp_top dut (.*);

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("Test %s %s", name, (errors == err_before) ? "ok" : "had errors");
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < 4; i++) begin
      m_cfg[i] = '0;
      m_addr[i] = '0;
    end
    m_rlb = 1'b0;
  endtask

  // Legalization rules applied to the reference registers
  task automatic update_model(input logic [7:0] offs, input logic [31:0] d);
    logic [7:0] nb;
    logic any_lock;
    logic frozen;
    any_lock = 1'b0;
    for (int i = 0; i < 4; i++) any_lock |= m_cfg[i][7];
    if (offs == 8'h00) begin
      for (int i = 0; i < 4; i++) begin
        nb = d[8*i +: 8];
        if (nb[2:0] == 3'd2 || nb[2:0] == 3'd6) nb[2:0] = m_cfg[i][2:0];
        if (m_cfg[i][7] && !m_rlb) nb = m_cfg[i];
        nb[6:5] = 2'b00;
        m_cfg[i] = nb;
      end
    end else if (offs >= 8'h10 && offs <= 8'h1c && offs[1:0] == 2'b00) begin
      for (int i = 0; i < 4; i++) begin
        if (offs == 8'h10 + 8'(4 * i)) begin
          frozen = m_cfg[i][7] && !m_rlb;
          if (i < 3 && m_cfg[i+1][7] && m_cfg[i+1][4:3] == 2'd1 && !m_rlb) frozen = 1'b1;
          if (!frozen) m_addr[i] = d;
        end
      end
    end else if (offs == 8'h20) begin
      m_rlb = d[2] & (m_rlb | ~any_lock);
    end
  endtask

  function automatic logic [31:0] expected_reg(input logic [7:0] offs);
    if (offs == 8'h00) return {m_cfg[3], m_cfg[2], m_cfg[1], m_cfg[0]};
    for (int i = 0; i < 4; i++) begin
      if (offs == 8'h10 + 8'(4 * i)) return m_addr[i];
    end
    if (offs == 8'h20) return {29'b0, m_rlb, 2'b00};
    return 32'h0;
  endfunction

  function automatic logic region_hit(input int i, input logic [31:0] a);
    logic [31:0] wa;
    logic [31:0] lo;
    int t;
    wa = a >> 2;
    lo = (i == 0) ? 32'h0 : m_addr[i-1];
    case (m_cfg[i][4:3])
      2'd1: return (wa >= lo) && (wa < m_addr[i]);
      2'd2: return wa == m_addr[i];
      2'd3: begin
        t = 0;
        while (t < 32 && m_addr[i][t]) t++;
        return ({32'b0, wa} >> (t + 1)) == ({32'b0, m_addr[i]} >> (t + 1));
      end
      default: return 1'b0;
    endcase
  endfunction

  task automatic expect_rsp(input logic [31:0] a, input logic [1:0] ty, input logic [1:0] pv,
                            output logic allow, output logic hit);
    int sel;
    sel = -1;
    for (int i = 3; i >= 0; i--) if (region_hit(i, a)) sel = i;
    hit = (sel >= 0);
    if (sel < 0) allow = (pv == 2'd3);
    else if (pv == 2'd3 && !m_cfg[sel][7]) allow = 1'b1;
    else allow = m_cfg[sel][ty];
  endtask

  task automatic axi_write(input logic [7:0] offs, input logic [31:0] d,
                           input logic [1:0] exp_resp);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    s_awvalid_i = 1'b1;
    s_wvalid_i = 1'b1;
    s_awaddr_i = offs;
    s_wdata_i = d;
    s_wstrb_i = 4'hf;
    #1;
    while (!s_awready_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (cnt >= TIMEOUT) report_timeout("AXI write address ready");
    // Data is taken together with the address
    check_eq("s_wready_o", {31'b0, s_wready_o}, 32'h1);
    @(negedge clk_i);
    s_awvalid_i = 1'b0;
    s_wvalid_i = 1'b0;
    cnt = 0;
    #1;
    while (!s_bvalid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (cnt >= TIMEOUT) report_timeout("AXI write response");
    check_eq("s_bresp_o", {30'b0, s_bresp_o}, {30'b0, exp_resp});
    // Response waits one cycle before it is accepted
    @(negedge clk_i);
    s_bready_i = 1'b1;
    @(negedge clk_i);
    s_bready_i = 1'b0;
    if (exp_resp == 2'd0) update_model(offs, d);
  endtask

  task automatic axi_read(input logic [7:0] offs, input logic [1:0] exp_resp);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    s_arvalid_i = 1'b1;
    s_araddr_i = offs;
    #1;
    while (!s_arready_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (cnt >= TIMEOUT) report_timeout("AXI read address ready");
    @(negedge clk_i);
    s_arvalid_i = 1'b0;
    cnt = 0;
    #1;
    while (!s_rvalid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (cnt >= TIMEOUT) report_timeout("AXI read data");
    // Read data sits one cycle before it is accepted
    @(negedge clk_i);
    s_rready_i = 1'b1;
    #1;
    check_eq("s_rvalid_o", {31'b0, s_rvalid_o}, 32'h1);
    check_eq("s_rdata_o", s_rdata_o, expected_reg(offs));
    check_eq("s_rresp_o", {30'b0, s_rresp_o}, {30'b0, exp_resp});
    @(negedge clk_i);
    s_rready_i = 1'b0;
  endtask

  // Returns right after the rising edge that transfers the request
  task automatic send_req(input logic [31:0] a, input logic [1:0] ty, input logic [1:0] pv);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_addr_i = a;
    req_type_i = pmp_pkg::access_e'(ty);
    req_priv_i = pv;
    #1;
    while (!req_ready_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (cnt >= TIMEOUT) report_timeout("request ready");
    @(posedge clk_i);
  endtask

  task automatic get_rsp(input logic [31:0] a, input logic [1:0] ty, input logic [1:0] pv);
    int cnt;
    logic ea;
    logic eh;
    cnt = 0;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    #1;
    while (!rsp_valid_o && cnt < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      cnt++;
    end
    if (cnt >= TIMEOUT) report_timeout("response valid");
    expect_rsp(a, ty, pv, ea, eh);
    check_eq("rsp_allow_o", {31'b0, rsp_allow_o}, {31'b0, ea});
    check_eq("rsp_hit_o", {31'b0, rsp_hit_o}, {31'b0, eh});
  endtask

  task automatic random_cfg_writes();
    int e;
    logic [31:0] d;
    e = errors;
    for (int n = 0; n < 20; n++) begin
      d = $random(seed);
      // Keep every entry unlocked
      d = d & 32'h7f7f_7f7f;
      axi_write(8'h00, d, 2'd0);
      axi_read(8'h00, 2'd0);
    end
    axi_write(8'h40, 32'hffff_ffff, 2'd2);
    axi_read(8'h44, 2'd2);
    finish_test("legalize", e);
  endtask

  task automatic lock_entry();
    int e;
    e = errors;
    apply_reset();
    axi_write(8'h14, 32'h0000_0abc, 2'd0);
    axi_write(8'h00, 32'h0000_8900, 2'd0);
    axi_write(8'h00, 32'h0000_0f00, 2'd0);
    axi_read(8'h00, 2'd0);
    axi_write(8'h14, 32'h0000_1234, 2'd0);
    axi_read(8'h14, 2'd0);
    check_eq("pmpaddr1", s_rdata_o, 32'h0000_0abc);
    axi_write(8'h20, 32'h0000_0004, 2'd0);
    axi_read(8'h20, 2'd0);
    check_eq("mseccfg", s_rdata_o, 32'h0);
    apply_reset();
    axi_write(8'h20, 32'h0000_0004, 2'd0);
    axi_write(8'h00, 32'h0000_8900, 2'd0);
    axi_write(8'h00, 32'h0000_0300, 2'd0);
    axi_read(8'h00, 2'd0);
    check_eq("pmpcfg0", s_rdata_o, 32'h0000_0300);
    finish_test("lock", e);
  endtask

  task automatic locked_tor_base();
    int e;
    e = errors;
    apply_reset();
    axi_write(8'h14, 32'h0000_0100, 2'd0);
    axi_write(8'h00, 32'h0089_0000, 2'd0);
    axi_write(8'h14, 32'h0000_0200, 2'd0);
    axi_write(8'h10, 32'h0000_0040, 2'd0);
    axi_read(8'h14, 2'd0);
    check_eq("pmpaddr1", s_rdata_o, 32'h0000_0100);
    axi_read(8'h10, 2'd0);
    check_eq("pmpaddr0", s_rdata_o, 32'h0000_0040);
    finish_test("tor_lock", e);
  endtask

  task automatic sweep(input logic [1:0] pv);
    logic [31:0] addrs [8];
    addrs = '{32'h0100, 32'h1000, 32'h1800, 32'h1ffc, 32'h2000, 32'h3ffc, 32'h4000, 32'h8000};
    for (int k = 0; k < 8; k++) begin
      for (int ty = 0; ty < 3; ty++) begin
        send_req(addrs[k], 2'(ty), pv);
        get_rsp(addrs[k], 2'(ty), pv);
      end
    end
  endtask

  task automatic match_regions();
    int e;
    e = errors;
    apply_reset();
    // NAPOT over 0x1000..0x1fff followed by TOR up to 0x4000
    axi_write(8'h10, 32'h0000_05ff, 2'd0);
    axi_write(8'h14, 32'h0000_1000, 2'd0);
    axi_write(8'h00, 32'h0000_0f19, 2'd0);
    sweep(2'd0);
    send_req(32'h8000, 2'd0, 2'd0);
    get_rsp(32'h8000, 2'd0, 2'd0);
    check_eq("rsp_allow_o", {31'b0, rsp_allow_o}, 32'h0);
    check_eq("rsp_hit_o", {31'b0, rsp_hit_o}, 32'h0);
    finish_test("match", e);
  endtask

  task automatic privilege_rules();
    int e;
    e = errors;
    sweep(2'd3);
    axi_write(8'h00, 32'h0000_0f99, 2'd0);
    send_req(32'h1000, 2'd1, 2'd3);
    get_rsp(32'h1000, 2'd1, 2'd3);
    check_eq("rsp_allow_o", {31'b0, rsp_allow_o}, 32'h0);
    finish_test("priv", e);
  endtask

  task automatic pipelined_flow();
    int e;
    int got;
    int cnt;
    logic [31:0] pa [8];
    logic [1:0] pt [8];
    logic ea;
    logic eh;
    e = errors;
    for (int k = 0; k < 8; k++) begin
      pa[k] = 32'h0800 * k;
      pt[k] = 2'(k % 3);
    end
    @(negedge clk_i);
    rsp_ready_i = 1'b0;
    send_req(pa[0], pt[0], 2'd0);
    send_req(pa[1], pt[1], 2'd0);
    got = 0;
    fork
      begin
        for (int k = 2; k < 8; k++) send_req(pa[k], pt[k], 2'd0);
        @(negedge clk_i);
        req_valid_i = 1'b0;
      end
      begin
        // Third request is offered while both stages are full
        @(negedge clk_i);
        #1;
        check_eq("req_ready_o", {31'b0, req_ready_o}, 32'h0);
        @(negedge clk_i);
        rsp_ready_i = 1'b1;
        cnt = 0;
        #1;
        while (got < 8 && cnt < TIMEOUT) begin
          if (rsp_valid_o) begin
            expect_rsp(pa[got], pt[got], 2'd0, ea, eh);
            check_eq("rsp_allow_o", {31'b0, rsp_allow_o}, {31'b0, ea});
            check_eq("rsp_hit_o", {31'b0, rsp_hit_o}, {31'b0, eh});
            got++;
          end
          @(negedge clk_i);
          #1;
          cnt++;
        end
        if (got < 8) report_timeout("pipelined responses");
      end
    join
    // Fixed latency of two cycles without back-pressure
    for (int k = 0; k < 4; k++) begin
      send_req(pa[k], pt[k], 2'd0);
      @(negedge clk_i);
      req_valid_i = 1'b0;
      #1;
      if (rsp_valid_o) begin
        $display("Response arrived one cycle after the request");
        errors++;
      end
      @(negedge clk_i);
      #1;
      check_eq("rsp_valid_o", {31'b0, rsp_valid_o}, 32'h1);
      expect_rsp(pa[k], pt[k], 2'd0, ea, eh);
      check_eq("rsp_allow_o", {31'b0, rsp_allow_o}, {31'b0, ea});
    end
    finish_test("pipeline", e);
  endtask

  initial begin
    apply_reset();
    random_cfg_writes();
    lock_entry();
    locked_tor_base();
    match_regions();
    privilege_rules();
    pipelined_flow();
    repeat (4) @(negedge clk_i);
    $display("Tests run: %0d, failed checks: %0d", tests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Overall guard in case a loop never ends
  initial begin
    #400000;
    $display("Simulation ran too long");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
pmp_pkg.sv
pmp_csr_regs.sv
pmp_region_match.sv
pmp_priority_check.sv
pmp_top.sv
tb_pmp_assert.sv
tb_pmp.sv

//--- run.sh
#!/bin/sh
# Build and run the PMP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_pmp -o sim_pmp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_pmp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1
